/* rtl/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	typedef enum logic [5:0] {
		LDA, LDX, LDY, ADC, SBC, AND, ORA, EOR,
		STA, STX, STY, ASL, LSR, ROL, ROR,
		INX, INY, DEX, DEY, TAX, TAY, TSX, TXA, TXS, TYA,
		CLC, SEC, JMP, JSR, NOP
	} opcode_e;

	typedef enum logic [1:0] {Imp, Imm, Abs} addressing_e;

	typedef enum logic [3:0] {
		ALUTXA, ALUTXB, ALUADD, ALUSUB, ALUAND, ALUORA,
		ALUEOR, ALUASL, ALULSR, ALUROL, ALUROR
	} alu_func_e;

	typedef enum logic {Con0, Con1} const_sel_e;

	// One-hot source enables for ALU input A
	typedef struct packed {
		logic bus;
		logic con;
		const_sel_e consel;
		logic acc;
		logic x;
		logic y;
		logic p;
		logic sp;
		logic adl;
		logic adh;
		logic pcl;
		logic pch;
	} alu_bus_a_t;

	typedef struct packed {
		logic bus;
		logic con;
		const_sel_e consel;
	} alu_bus_b_t;

	// Destinations that take the ALU result
	typedef struct packed {
		logic bus;
		logic acc;
		logic x;
		logic y;
		logic sp;
		logic adl;
		logic adh;
		logic pcl;
		logic pch;
	} alu_bus_o_t;

	typedef logic [7:0] status_t;

	typedef struct packed {
		logic n;
		logic z;
		logic c;
		logic v;
	} alu_flags_t;

	localparam int STATUS_C = 0;
	localparam int STATUS_Z = 1;
	localparam int STATUS_I = 2;
	localparam int STATUS_D = 3;
	localparam int STATUS_B = 4;
	localparam int STATUS_R = 5;
	localparam int STATUS_V = 6;
	localparam int STATUS_N = 7;

	localparam logic [15:0] RESET_VECTOR = 16'hFFFC;

endpackage

`default_nettype wire

/* rtl/instr_decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
	input wire logic [7:0] ir_i,
	output cpu_pkg::opcode_e opcode_o,
	output cpu_pkg::addressing_e mode_o
);
	import cpu_pkg::*;

	always_comb begin
		case (ir_i)
		8'hA9, 8'hAD: opcode_o = LDA;
		8'hA2, 8'hAE: opcode_o = LDX;
		8'hA0, 8'hAC: opcode_o = LDY;
		8'h69, 8'h6D: opcode_o = ADC;
		8'hE9, 8'hED: opcode_o = SBC;
		8'h29, 8'h2D: opcode_o = AND;
		8'h09, 8'h0D: opcode_o = ORA;
		8'h49, 8'h4D: opcode_o = EOR;
		8'h8D: opcode_o = STA;
		8'h8E: opcode_o = STX;
		8'h8C: opcode_o = STY;
		8'h0A: opcode_o = ASL;
		8'h4A: opcode_o = LSR;
		8'h2A: opcode_o = ROL;
		8'h6A: opcode_o = ROR;
		8'hE8: opcode_o = INX;
		8'hC8: opcode_o = INY;
		8'hCA: opcode_o = DEX;
		8'h88: opcode_o = DEY;
		8'hAA: opcode_o = TAX;
		8'hA8: opcode_o = TAY;
		8'hBA: opcode_o = TSX;
		8'h8A: opcode_o = TXA;
		8'h9A: opcode_o = TXS;
		8'h98: opcode_o = TYA;
		8'h18: opcode_o = CLC;
		8'h38: opcode_o = SEC;
		8'h4C: opcode_o = JMP;
		8'h20: opcode_o = JSR;
		default: opcode_o = NOP;
		endcase
	end

	always_comb begin
		case (ir_i)
		8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49: mode_o = Imm;
		8'hAD, 8'hAE, 8'hAC, 8'h6D, 8'hED, 8'h2D, 8'h0D, 8'h4D,
		8'h8D, 8'h8E, 8'h8C, 8'h4C, 8'h20: mode_o = Abs;
		default: mode_o = Imp;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module sequencer (
	input wire logic sys,
	input wire logic rst_n_i,
	input wire cpu_pkg::opcode_e opcode_i,
	input wire cpu_pkg::addressing_e mode_i,
	output logic bus_we_o,
	output logic pc_addr_oe_o,
	output logic pc_inc_o,
	output logic pc_load_o,
	output logic ad_addr_oe_o,
	output logic ins_we_o,
	output cpu_pkg::alu_bus_a_t abus_a_o,
	output cpu_pkg::alu_bus_b_t abus_b_o,
	output cpu_pkg::alu_bus_o_t abus_o_o,
	output cpu_pkg::alu_func_e alu_func_o,
	output cpu_pkg::status_t p_mask_o,
	output cpu_pkg::status_t p_set_o,
	output cpu_pkg::status_t p_clr_o
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {Fetch, Decode, ReadH, Absolute, JumpL, JumpH} state_e;

	state_e state;
	state_e state_next;
	logic execute;

	always_ff @(posedge sys or negedge rst_n_i) begin
		if (!rst_n_i)
			state <= JumpL;
		else
			state <= state_next;
	end

	always_comb begin
		bus_we_o = 1'b0;
		pc_addr_oe_o = 1'b0;
		ad_addr_oe_o = 1'b0;
		pc_inc_o = 1'b0;
		pc_load_o = 1'b0;
		ins_we_o = 1'b0;
		abus_a_o = '0;
		abus_a_o.bus = 1'b1;
		abus_b_o = '0;
		abus_b_o.bus = 1'b1;
		abus_o_o = '0;
		alu_func_o = ALUTXB;
		p_mask_o = '0;
		p_set_o = '0;
		p_clr_o = '0;
		state_next = state;
		execute = 1'b0;

		case (state)
		Fetch: begin
			pc_addr_oe_o = 1'b1;
			pc_inc_o = 1'b1;
			ins_we_o = 1'b1;
			state_next = Decode;
		end
		Decode: begin
			pc_addr_oe_o = 1'b1;
			pc_inc_o = (mode_i != Imp);
			if (mode_i == Abs) begin
				abus_o_o.adl = 1'b1;
				state_next = ReadH;
			end else begin
				execute = 1'b1;
				state_next = Fetch;
			end
		end
		ReadH: begin
			pc_addr_oe_o = 1'b1;
			abus_o_o.adh = 1'b1;
			if (opcode_i == JMP || opcode_i == JSR) begin
				pc_load_o = 1'b1;
				state_next = Fetch;
			end else begin
				pc_inc_o = 1'b1;
				state_next = Absolute;
			end
		end
		Absolute: begin
			ad_addr_oe_o = 1'b1;
			execute = 1'b1;
			state_next = Fetch;
		end
		// Vector low byte, then high byte straight into PC
		JumpL: begin
			pc_addr_oe_o = 1'b1;
			pc_inc_o = 1'b1;
			abus_o_o.adl = 1'b1;
			state_next = JumpH;
		end
		JumpH: begin
			pc_addr_oe_o = 1'b1;
			pc_load_o = 1'b1;
			abus_o_o.adh = 1'b1;
			state_next = Fetch;
		end
		default: state_next = JumpL;
		endcase

		if (execute) begin
			case (opcode_i)
			ADC, INX, INY: alu_func_o = ALUADD;
			SBC, DEX, DEY: alu_func_o = ALUSUB;
			AND: alu_func_o = ALUAND;
			ORA: alu_func_o = ALUORA;
			EOR: alu_func_o = ALUEOR;
			ASL: alu_func_o = ALUASL;
			LSR: alu_func_o = ALULSR;
			ROL: alu_func_o = ALUROL;
			ROR: alu_func_o = ALUROR;
			STA, STX, STY, TAX, TAY, TSX, TXA, TXS, TYA: alu_func_o = ALUTXA;
			default: alu_func_o = ALUTXB;
			endcase

			// Register operand on A, memory stays on B
			abus_a_o.acc = opcode_i inside {ADC, SBC, AND, ORA, EOR, ASL, LSR, ROL, ROR,
				STA, TAX, TAY};
			abus_a_o.x = opcode_i inside {INX, DEX, STX, TXA, TXS};
			abus_a_o.y = opcode_i inside {INY, DEY, STY, TYA};
			abus_a_o.sp = (opcode_i == TSX);
			abus_a_o.bus = !(abus_a_o.acc || abus_a_o.x || abus_a_o.y || abus_a_o.sp);

			if (opcode_i inside {INX, INY, DEX, DEY}) begin
				abus_b_o.bus = 1'b0;
				abus_b_o.con = 1'b1;
				abus_b_o.consel = Con1;
			end

			abus_o_o.acc = opcode_i inside {LDA, ADC, SBC, AND, ORA, EOR, ASL, LSR, ROL, ROR,
				TXA, TYA};
			abus_o_o.x = opcode_i inside {LDX, TAX, TSX, INX, DEX};
			abus_o_o.y = opcode_i inside {LDY, TAY, INY, DEY};
			abus_o_o.sp = (opcode_i == TXS);
			abus_o_o.bus = opcode_i inside {STA, STX, STY};
			bus_we_o = abus_o_o.bus;

			p_clr_o[STATUS_C] = (opcode_i == CLC);
			p_set_o[STATUS_C] = (opcode_i == SEC);
		end

		// Flags follow from the routing chosen above
		if (abus_o_o.acc || abus_o_o.x || abus_o_o.y) begin
			p_mask_o[STATUS_N] = 1'b1;
			p_mask_o[STATUS_Z] = 1'b1;
		end
		if ((alu_func_o inside {ALUADD, ALUSUB}) && !abus_b_o.con) begin
			p_mask_o[STATUS_C] = 1'b1;
			p_mask_o[STATUS_V] = 1'b1;
		end
		if (alu_func_o inside {ALUASL, ALULSR, ALUROL, ALUROR})
			p_mask_o[STATUS_C] = 1'b1;
	end

	assert property (@(posedge sys) disable iff (!rst_n_i)
		!(pc_addr_oe_o && ad_addr_oe_o));
	assert property (@(posedge sys) disable iff (!rst_n_i)
		bus_we_o |-> ad_addr_oe_o);

endmodule

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
	input wire cpu_pkg::alu_func_e func_i,
	input wire logic [7:0] a_i,
	input wire logic [7:0] b_i,
	input wire logic carry_i,
	output logic [7:0] result_o,
	output cpu_pkg::alu_flags_t flags_o
);
	import cpu_pkg::*;

	logic [8:0] sum;
	logic c;
	logic v;

	always_comb begin
		assert (!$isunknown(func_i)) else $error("ALU function unknown");
		sum = '0;
		result_o = b_i;
		c = carry_i;
		v = 1'b0;
		case (func_i)
		ALUTXA: result_o = a_i;
		ALUTXB: result_o = b_i;
		ALUADD: begin
			sum = {1'b0, a_i} + {1'b0, b_i} + {8'd0, carry_i};
			result_o = sum[7:0];
			c = sum[8];
			v = (a_i[7] == b_i[7]) && (sum[7] != a_i[7]);
		end
		// Carry set means no borrow
		ALUSUB: begin
			sum = {1'b0, a_i} + {1'b0, ~b_i} + {8'd0, carry_i};
			result_o = sum[7:0];
			c = sum[8];
			v = (a_i[7] != b_i[7]) && (sum[7] != a_i[7]);
		end
		ALUAND: result_o = a_i & b_i;
		ALUORA: result_o = a_i | b_i;
		ALUEOR: result_o = a_i ^ b_i;
		ALUASL: {c, result_o} = {a_i, 1'b0};
		ALULSR: {result_o, c} = {1'b0, a_i};
		ALUROL: {c, result_o} = {a_i, carry_i};
		ALUROR: {result_o, c} = {carry_i, a_i};
		default: result_o = b_i;
		endcase
	end

	assign flags_o = '{n: result_o[7], z: (result_o == 8'h00), c: c, v: v};

endmodule

`default_nettype wire

/* rtl/datapath.sv */
`timescale 1ns/1ns
`default_nettype none

module datapath (
	input wire logic sys,
	input wire logic rst_n_i,
	input wire logic [7:0] data_i,
	input wire logic bus_we_i,
	input wire logic pc_addr_oe_i,
	input wire logic pc_inc_i,
	input wire logic pc_load_i,
	input wire logic ad_addr_oe_i,
	input wire logic ins_we_i,
	input wire cpu_pkg::alu_bus_a_t abus_a_i,
	input wire cpu_pkg::alu_bus_b_t abus_b_i,
	input wire cpu_pkg::alu_bus_o_t abus_o_i,
	input wire cpu_pkg::alu_func_e alu_func_i,
	input wire cpu_pkg::status_t p_mask_i,
	input wire cpu_pkg::status_t p_set_i,
	input wire cpu_pkg::status_t p_clr_i,
	output logic [15:0] addr_o,
	output logic [7:0] data_o,
	output logic [7:0] ir_o
);
	import cpu_pkg::*;

	logic [7:0] acc, x, y, sp;
	logic [15:0] pc, ad;
	status_t p, p_next, flag_vec;
	logic [7:0] alu_a, alu_b, alu_result;
	logic alu_carry;
	alu_flags_t alu_flags;

	assign alu_a = ({8{abus_a_i.bus}} & data_i)
		| ({8{abus_a_i.con}} & {7'd0, abus_a_i.consel == Con1})
		| ({8{abus_a_i.acc}} & acc) | ({8{abus_a_i.x}} & x) | ({8{abus_a_i.y}} & y)
		| ({8{abus_a_i.p}} & p) | ({8{abus_a_i.sp}} & sp)
		| ({8{abus_a_i.adl}} & ad[7:0]) | ({8{abus_a_i.adh}} & ad[15:8])
		| ({8{abus_a_i.pcl}} & pc[7:0]) | ({8{abus_a_i.pch}} & pc[15:8]);
	assign alu_b = ({8{abus_b_i.bus}} & data_i)
		| ({8{abus_b_i.con}} & {7'd0, abus_b_i.consel == Con1});

	// Increment and decrement use the constant with a fixed carry
	assign alu_carry = abus_b_i.con ? (alu_func_i == ALUSUB) : p[STATUS_C];

	alu u_alu (
		.func_i(alu_func_i), .a_i(alu_a), .b_i(alu_b), .carry_i(alu_carry),
		.result_o(alu_result), .flags_o(alu_flags)
	);

	always_comb begin
		flag_vec = p;
		flag_vec[STATUS_N] = alu_flags.n;
		flag_vec[STATUS_Z] = alu_flags.z;
		flag_vec[STATUS_C] = alu_flags.c;
		flag_vec[STATUS_V] = alu_flags.v;
		p_next = ((p & ~p_mask_i) | (flag_vec & p_mask_i) | p_set_i) & ~p_clr_i;
		p_next[STATUS_R] = 1'b1;
	end

	assign addr_o = pc_addr_oe_i ? pc : ad;
	assign data_o = alu_result;

	always_ff @(posedge sys or negedge rst_n_i) begin
		if (!rst_n_i) begin
			ir_o <= '0;
			acc <= '0;
			x <= '0;
			y <= '0;
			sp <= '0;
			ad <= '0;
			p <= 8'h20;
			pc <= RESET_VECTOR;
		end else begin
			if (ins_we_i)
				ir_o <= data_i;
			if (abus_o_i.acc)
				acc <= alu_result;
			if (abus_o_i.x)
				x <= alu_result;
			if (abus_o_i.y)
				y <= alu_result;
			if (abus_o_i.sp)
				sp <= alu_result;
			if (abus_o_i.adl)
				ad[7:0] <= alu_result;
			if (abus_o_i.adh)
				ad[15:8] <= alu_result;
			p <= p_next;
			if (pc_load_i)
				pc <= {alu_result, ad[7:0]};
			else if (pc_inc_i)
				pc <= pc + 16'd1;
			else begin
				if (abus_o_i.pcl)
					pc[7:0] <= alu_result;
				if (abus_o_i.pch)
					pc[15:8] <= alu_result;
			end
		end
	end

	assert property (@(posedge sys) disable iff (!rst_n_i) !(pc_load_i && pc_inc_i));
	assert property (@(posedge sys) disable iff (!rst_n_i)
		$onehot0({abus_a_i.bus, abus_a_i.con, abus_a_i.acc, abus_a_i.x, abus_a_i.y,
			abus_a_i.p, abus_a_i.sp, abus_a_i.adl, abus_a_i.adh, abus_a_i.pcl, abus_a_i.pch}));

endmodule

`default_nettype wire

/* rtl/cpu_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
	input wire logic sys,
	input wire logic rst_n_i,
	input wire logic [7:0] data_i,
	output logic [15:0] addr_o,
	output logic [7:0] data_o,
	output logic we_o,
	output logic sync_o
);
	import cpu_pkg::*;

	opcode_e opcode;
	addressing_e mode;
	logic [7:0] ir;
	logic pc_addr_oe, pc_inc, pc_load, ad_addr_oe;
	alu_bus_a_t abus_a;
	alu_bus_b_t abus_b;
	alu_bus_o_t abus_o;
	alu_func_e alu_func;
	status_t p_mask, p_set, p_clr;

	instr_decoder u_decoder (.ir_i(ir), .opcode_o(opcode), .mode_o(mode));

	// Write strobe and fetch marker come straight from the sequencer
	sequencer u_sequencer (
		.sys(sys), .rst_n_i(rst_n_i), .opcode_i(opcode), .mode_i(mode),
		.bus_we_o(we_o), .pc_addr_oe_o(pc_addr_oe), .pc_inc_o(pc_inc),
		.pc_load_o(pc_load), .ad_addr_oe_o(ad_addr_oe), .ins_we_o(sync_o),
		.abus_a_o(abus_a), .abus_b_o(abus_b), .abus_o_o(abus_o), .alu_func_o(alu_func),
		.p_mask_o(p_mask), .p_set_o(p_set), .p_clr_o(p_clr)
	);

	datapath u_datapath (
		.sys(sys), .rst_n_i(rst_n_i), .data_i(data_i),
		.bus_we_i(we_o), .pc_addr_oe_i(pc_addr_oe), .pc_inc_i(pc_inc),
		.pc_load_i(pc_load), .ad_addr_oe_i(ad_addr_oe), .ins_we_i(sync_o),
		.abus_a_i(abus_a), .abus_b_i(abus_b), .abus_o_i(abus_o), .alu_func_i(alu_func),
		.p_mask_i(p_mask), .p_set_i(p_set), .p_clr_i(p_clr),
		.addr_o(addr_o), .data_o(data_o), .ir_o(ir)
	);

endmodule

`default_nettype wire

/* sim/tb_cpu.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cpu;
	logic sys;
	logic rst_n_i;
	logic [7:0] data_i;
	logic [15:0] addr_o;
	logic [7:0] data_o;
	logic we_o;
	logic sync_o;

	logic [7:0] mem [0:255];
	integer seed = 32'hb872_5490;

	// Expected fetch addresses, fetch spacing and stores
	logic [15:0] exp_pc [0:127];
	int exp_gap [0:127];
	string exp_iname [0:127];
	logic [15:0] exp_waddr [0:63];
	logic [7:0] exp_wdata [0:63];
	string exp_wname [0:63];
	int n_sync = 0;
	int n_wr = 0;
	int prev_len = 0;
	int pos = 0;
	int limit = 20;
	logic [7:0] page;
	string test_name;
	logic [7:0] m_a, m_x, m_y, m_sp;
	logic m_c;

	// Sampled on the falling edge, checked on the rising edge
	int widx = 0;
	int sidx = 0;
	int since = 0;
	int seen_gap = 0;
	int cycles = 0;
	int cur_gap = 0;
	logic [15:0] cur_pc, cur_waddr, st_addr;
	logic [7:0] cur_wdata, st_data;
	logic st_we = 1'b0;
	logic st_sync = 1'b0;
	logic sync_chk = 1'b0;
	logic extra_write = 1'b0;
	string cur_iname, cur_wname;

	cpu_top uut (
		.sys(sys), .rst_n_i(rst_n_i), .data_i(data_i), .addr_o(addr_o),
		.data_o(data_o), .we_o(we_o), .sync_o(sync_o)
	);

	// 256 bytes mirrored over the whole address space
	assign data_i = mem[addr_o[7:0]];

	function automatic logic [7:0] rand_byte();
		int r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic report_failure();
		$display("STATUS: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic put_byte(input logic [7:0] b);
		mem[pos] = b;
		pos++;
	endtask

	task automatic begin_instr(input logic [7:0] opc, input int len);
		exp_pc[n_sync] = {page, pos[7:0]};
		exp_gap[n_sync] = (n_sync == 0) ? 3 : prev_len;
		exp_iname[n_sync] = test_name;
		prev_len = len;
		limit += len;
		n_sync++;
		put_byte(opc);
	endtask

	task automatic load_reg(input int r, input bit absolute, input logic [7:0] val);
		logic [7:0] lo;
		logic [7:0] v;
		v = val;
		if (absolute) begin
			lo = 8'hF0 + (rand_byte() % 8'd12);
			begin_instr((r == 0) ? 8'hAD : (r == 1) ? 8'hAE : 8'hAC, 4);
			put_byte(lo);
			put_byte(rand_byte());
			v = mem[lo];
		end else begin
			begin_instr((r == 0) ? 8'hA9 : (r == 1) ? 8'hA2 : 8'hA0, 2);
			put_byte(v);
		end
		case (r)
		0: m_a = v;
		1: m_x = v;
		default: m_y = v;
		endcase
	endtask

	task automatic store_reg(input int r);
		logic [7:0] lo;
		logic [7:0] hi;
		lo = 8'hE0 + (rand_byte() & 8'h0F);
		hi = rand_byte();
		begin_instr((r == 0) ? 8'h8D : (r == 1) ? 8'h8E : 8'h8C, 4);
		put_byte(lo);
		put_byte(hi);
		exp_waddr[n_wr] = {hi, lo};
		exp_wdata[n_wr] = (r == 0) ? m_a : (r == 1) ? m_x : m_y;
		exp_wname[n_wr] = test_name;
		n_wr++;
	endtask

	task automatic implied(input logic [7:0] opc);
		logic t;
		begin_instr(opc, 2);
		t = m_c;
		case (opc)
		8'h0A: begin
			m_c = m_a[7];
			m_a = {m_a[6:0], 1'b0};
		end
		8'h4A: begin
			m_c = m_a[0];
			m_a = {1'b0, m_a[7:1]};
		end
		8'h2A: begin
			m_c = m_a[7];
			m_a = {m_a[6:0], t};
		end
		8'h6A: begin
			m_c = m_a[0];
			m_a = {t, m_a[7:1]};
		end
		8'hE8: m_x = m_x + 8'd1;
		8'hC8: m_y = m_y + 8'd1;
		8'hCA: m_x = m_x - 8'd1;
		8'h88: m_y = m_y - 8'd1;
		8'hAA: m_x = m_a;
		8'hA8: m_y = m_a;
		8'hBA: m_x = m_sp;
		8'h8A: m_a = m_x;
		8'h9A: m_sp = m_x;
		8'h98: m_a = m_y;
		8'h18: m_c = 1'b0;
		8'h38: m_c = 1'b1;
		default: ;
		endcase
	endtask

	// Kinds: ADC, SBC, AND, ORA, EOR; absolute opcode is immediate plus 4
	task automatic alu_op(input int k, input bit absolute);
		logic [7:0] opc;
		logic [7:0] b;
		logic [7:0] lo;
		int r;
		case (k)
		0: opc = 8'h69;
		1: opc = 8'hE9;
		2: opc = 8'h29;
		3: opc = 8'h09;
		default: opc = 8'h49;
		endcase
		if (absolute) begin
			lo = 8'hF0 + (rand_byte() % 8'd12);
			begin_instr(opc + 8'h04, 4);
			put_byte(lo);
			put_byte(rand_byte());
			b = mem[lo];
		end else begin
			b = rand_byte();
			begin_instr(opc, 2);
			put_byte(b);
		end
		case (k)
		0: begin
			r = int'(m_a) + int'(b) + int'(m_c);
			m_c = (r > 255);
			m_a = r[7:0];
		end
		1: begin
			r = int'(m_a) - int'(b) - (1 - int'(m_c));
			m_c = (r >= 0);
			m_a = r[7:0];
		end
		2: m_a = m_a & b;
		3: m_a = m_a | b;
		default: m_a = m_a ^ b;
		endcase
	endtask

	task automatic jump_to(input logic [7:0] opc);
		logic [7:0] target;
		target = pos[7:0] + 8'd3 + (rand_byte() & 8'h07);
		begin_instr(opc, 3);
		put_byte(target);
		put_byte(page);
		pos = int'(target);
	endtask

	task automatic build_program();
		int i;
		logic [7:0] r;
		for (i = 0; i < 256; i++)
			mem[i] = rand_byte();
		page = rand_byte();
		mem[8'hFC] = 8'h00;
		mem[8'hFD] = page;
		{m_a, m_x, m_y, m_sp, m_c} = '0;
		test_name = "load_store";
		for (i = 0; i < 6; i++) begin
			load_reg(i % 3, i >= 3, rand_byte());
			store_reg(i % 3);
		end
		test_name = "jmp";
		jump_to(8'h4C);
		for (i = 0; i < 10; i++) begin
			test_name = "alu";
			r = rand_byte();
			implied(r[0] ? 8'h38 : 8'h18);
			alu_op(i % 5, i >= 5);
			store_reg(0);
			// Carry out of ADC and SBC lands in bit 0
			if (i % 5 < 2) begin
				test_name = "carry";
				load_reg(0, 1'b0, 8'h00);
				implied(8'h2A);
				store_reg(0);
			end
		end
		test_name = "jsr";
		jump_to(8'h20);
		test_name = "shift";
		load_reg(0, 1'b0, rand_byte());
		implied(8'h0A);
		implied(8'h2A);
		store_reg(0);
		implied(8'h4A);
		implied(8'h6A);
		store_reg(0);
		test_name = "inc_dec";
		load_reg(1, 1'b0, 8'hFF);
		implied(8'hE8);
		store_reg(1);
		implied(8'hCA);
		store_reg(1);
		load_reg(2, 1'b0, 8'hFF);
		implied(8'hC8);
		store_reg(2);
		implied(8'h88);
		store_reg(2);
		test_name = "transfer";
		load_reg(0, 1'b0, rand_byte());
		implied(8'hAA);
		implied(8'hA8);
		store_reg(1);
		store_reg(2);
		load_reg(1, 1'b0, rand_byte());
		implied(8'h8A);
		store_reg(0);
		load_reg(2, 1'b0, rand_byte());
		implied(8'h98);
		store_reg(0);
		load_reg(1, 1'b0, rand_byte());
		implied(8'h9A);
		load_reg(1, 1'b0, rand_byte());
		implied(8'hBA);
		store_reg(1);
		// Park on a jump to itself
		test_name = "park";
		r = pos[7:0];
		begin_instr(8'h4C, 3);
		put_byte(r);
		put_byte(page);
	endtask

	always @(negedge sys) begin
		st_we = we_o;
		st_sync = sync_o;
		st_addr = addr_o;
		st_data = data_o;
		if (!rst_n_i) begin
			since = 1;
		end else begin
			cycles++;
			since++;
			if (sync_o) begin
				sync_chk = (sidx < n_sync);
				if (sync_chk) begin
					cur_pc = exp_pc[sidx];
					cur_gap = exp_gap[sidx];
					cur_iname = exp_iname[sidx];
				end
				seen_gap = since;
				since = 0;
				sidx++;
			end
			if (we_o) begin
				extra_write = (widx >= n_wr);
				if (!extra_write) begin
					cur_waddr = exp_waddr[widx];
					cur_wdata = exp_wdata[widx];
					cur_wname = exp_wname[widx];
				end
				widx++;
			end
		end
	end

	assert property (@(posedge sys) !rst_n_i |-> !we_o)
		else begin
			$display("Write strobe went high during reset");
			report_failure();
		end
	assert property (@(posedge sys) disable iff (!rst_n_i) !extra_write)
		else begin
			$display("Store seen after the last expected one");
			report_failure();
		end
	assert property (@(posedge sys) disable iff (!rst_n_i)
		(st_we && !extra_write) |-> (st_addr == cur_waddr))
		else begin
			$display("Fail %s store address: expected %h, actual %h", cur_wname, cur_waddr,
				st_addr);
			report_failure();
		end
	assert property (@(posedge sys) disable iff (!rst_n_i)
		(st_we && !extra_write) |-> (st_data == cur_wdata))
		else begin
			$display("Fail %s store data: expected %h, actual %h", cur_wname, cur_wdata,
				st_data);
			report_failure();
		end
	assert property (@(posedge sys) disable iff (!rst_n_i)
		(st_sync && sync_chk) |-> (st_addr == cur_pc))
		else begin
			$display("Fail %s fetch address: expected %h, actual %h", cur_iname, cur_pc,
				st_addr);
			report_failure();
		end
	assert property (@(posedge sys) disable iff (!rst_n_i)
		(st_sync && sync_chk) |-> (seen_gap == cur_gap))
		else begin
			$display("Fail %s cycles before fetch: expected %0d, actual %0d", cur_iname,
				cur_gap, seen_gap);
			report_failure();
		end

	initial begin
		sys = 1'b0;
		forever #20 sys = ~sys;
	end

	initial begin
		rst_n_i = 1'b0;
		build_program();
		repeat (4) @(negedge sys);
		rst_n_i <= 1'b1;
		// Run on until the parking jump has come back to itself once
		while ((widx < n_wr || sidx <= n_sync) && cycles < limit)
			@(posedge sys);
		if (widx < n_wr || sidx <= n_sync) begin
			$display("Timeout after %0d cycles with %0d of %0d stores seen", cycles, widx,
				n_wr);
			report_failure();
		end else begin
			@(negedge sys);
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tb.f */
rtl/cpu_pkg.sv
rtl/instr_decoder.sv
rtl/sequencer.sv
rtl/alu.sv
rtl/datapath.sv
rtl/cpu_top.sv
sim/tb_cpu.sv

/* Makefile */
TOP = tb_cpu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/1ns --top-module $(TOP) -f tb.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
